//--- Makefile
SIM       ?= verilator
TOP       ?= tbWb
FILELIST  ?= vlog.f
FLAGS     ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing --assert
RUNARGS   ?= +verilator+error+limit+100
BUILDDIR  ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)

# Pass only when the pass line shows up in the output
run: build
	@out=$$(./$(BUILDDIR)/V$(TOP) $(RUNARGS) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR)

//--- sim/tbWb.sv
/*
 * Testbench for wbTop, driving four-phase req/ack transactions.
 * Inputs change on the falling clock edge and outputs are sampled there.
 * A register and RAM model gives the expected rspData and misaligned.
 * Loads and stores address the RAM from R0 plus the immediate.
 * The first failed check stops the run.
 */
module tbWb import coreDefs::*;;

   // Op count of all phases below, back-pressure ops hold up to 6 cycles
   localparam int opCount       = 105;
   localparam int holdMax       = 6;
   localparam int timeoutCycles = 3 + 64 + opCount * 6 + 4 * holdMax + 100;

   logic        gclk;
   logic        arstN;
   logic        req;
   logic [31:0] opWord;
   logic        ack;
   logic [31:0] rspData;
   logic        misaligned;
   logic [31:0] seed = 32'd22;
   logic [31:0] regModel [32];
   logic [31:0] ramModel [64];
   int          cycleCount = 0;

   wbTop u_wbTop (
      .gclk       (gclk),
      .arstN      (arstN),
      .req        (req),
      .opWord     (opWord),
      .ack        (ack),
      .rspData    (rspData),
      .misaligned (misaligned)
   );

   initial begin
      gclk = 1'b0;
      forever #2 gclk = ~gclk;
   end

   task automatic reportFailure();
      $display("Testbench failed");
      $fatal(1);
   endtask

   // Linear congruential generator
   function automatic logic [31:0] nextRand();
      seed = seed * 32'd1103515245 + 32'd12345;
      return {8'd0, seed[31:8]};
   endfunction

   function automatic logic [31:0] signExt(input logic [16:0] imm);
      return {{15{imm[16]}}, imm};
   endfunction

   // Flag, opcode, rd, ra, then rb or the 17-bit immediate
   function automatic logic [31:0] encodeOp(input opKindE kind, input bit immF,
         input logic [4:0] rd, input logic [4:0] ra, input logic [4:0] rb,
         input logic [16:0] imm);
      if (immF) begin
         return {1'b1, kind, rd, ra, imm};
      end
      return {1'b0, kind, rd, ra, rb, 12'd0};
   endfunction

   task automatic checkEq(input string name, input string what,
         input logic [31:0] expVal, input logic [31:0] actVal);
      assert (actVal === expVal)
      else begin
         $display("Error %s %s expected %h actual %h", name, what, expVal, actVal);
         reportFailure();
      end
   endtask

   // One transaction against the model, hold keeps req up after ack
   task automatic runOp(input string name, input opKindE kind, input bit immF,
         input logic [4:0] rd, input logic [4:0] ra, input logic [4:0] rb,
         input logic [16:0] imm, input int hold);
      logic [31:0] opB;
      logic [31:0] addr;
      logic [31:0] word;
      logic [31:0] expData;
      logic        expMis;
      int          w;
      int          byteSh;
      int          halfSh;
      expMis  = 1'b0;
      expData = '0;
      opB     = immF ? signExt(imm) : regModel[rb];
      addr    = regModel[ra] + signExt(imm);
      w       = int'(addr[7:2]);
      word    = ramModel[w];
      // Big-endian lanes
      byteSh  = 24 - 8 * int'(addr[1:0]);
      halfSh  = addr[1] ? 0 : 16;
      case (kind)
         ADD:    expData = regModel[ra] + opB;
         SUB:    expData = regModel[ra] - opB;
         AND:    expData = regModel[ra] & opB;
         XOR:    expData = regModel[ra] ^ opB;
         LOADB:  expData = {24'd0, word[byteSh +: 8]};
         LOADH: begin
            expMis  = addr[0];
            expData = {16'd0, word[halfSh +: 16]};
         end
         LOADW: begin
            expMis  = (addr[1:0] != 2'b00);
            expData = word;
         end
         STOREH: expMis = addr[0];
         STOREW: expMis = (addr[1:0] != 2'b00);
         default: expData = '0;
      endcase
      if (kind inside {STOREB, STOREH, STOREW}) begin
         expData = regModel[rd];
      end
      if (expMis) begin
         expData = '0;
      end
      @(negedge gclk);
      opWord = encodeOp(kind, immF, rd, ra, rb, imm);
      req    = 1'b1;
      @(negedge gclk);
      while (!ack) @(negedge gclk);
      checkEq(name, "rspData", expData, rspData);
      checkEq(name, "misaligned", {31'd0, expMis}, {31'd0, misaligned});
      repeat (hold) begin
         @(negedge gclk);
         checkEq(name, "held ack", 32'd1, {31'd0, ack});
         checkEq(name, "held rspData", expData, rspData);
      end
      req = 1'b0;
      while (ack) @(negedge gclk);
      // Model update, R0 never written
      if (!expMis) begin
         case (kind)
            STOREB: ramModel[w][byteSh +: 8] = regModel[rd][7:0];
            STOREH: ramModel[w][halfSh +: 16] = regModel[rd][15:0];
            STOREW: ramModel[w] = regModel[rd];
            default: begin
               if (rd != 5'd0) begin
                  regModel[rd] = expData;
               end
            end
         endcase
      end
   endtask

   // Timeout guard
   always @(posedge gclk) begin
      cycleCount++;
      if (cycleCount >= timeoutCycles) begin
         $display("Timeout after %0d cycles, ack never arrived", cycleCount);
         reportFailure();
      end
   end

   // Bound property failures end the run at once
   always @(negedge gclk) begin
      if (u_wbTop.u_wbProps.failCount != 0) begin
         $display("A handshake property of wbTop failed");
         reportFailure();
      end
   end

   initial begin
      opKindE     kind;
      logic [4:0] src;
      int         base;
      arstN  = 1'b0;
      req    = 1'b0;
      opWord = '0;
      for (int i = 0; i < 32; i++) regModel[i] = '0;
      for (int i = 0; i < 64; i++) ramModel[i] = '0;
      repeat (3) @(negedge gclk);
      arstN = 1'b1;

      // Immediate loads into R1..R8, read back through R0
      for (int i = 1; i <= 8; i++) runOp("addImm", ADD, 1, 5'(i), 0, 0, 17'(nextRand()), 0);
      for (int i = 1; i <= 8; i++) runOp("readBack", ADD, 0, 5'(20 + i), 5'(i), 0, '0, 0);

      // Random ALU ops, both forms
      for (int i = 0; i < 24; i++) begin
         kind = opKindE'(nextRand() % 4);
         runOp("aluRandom", kind, nextRand() % 2 == 1, 5'(1 + nextRand() % 31),
               5'(nextRand()), 5'(nextRand()), 17'(nextRand()), 0);
      end

      // R0 write is dropped
      runOp("r0Write", ADD, 1, 0, 3, 0, 17'(nextRand()), 0);
      runOp("r0Read", ADD, 0, 9, 0, 0, '0, 0);

      // Stores then loads of every size and offset
      for (int i = 0; i < 4; i++) begin
         base = 4 * int'(nextRand() % 64);
         src  = 5'(1 + nextRand() % 31);
         runOp("storeW", STOREW, 1, src, 0, 0, 17'(base), 0);
         runOp("loadW", LOADW, 1, 10, 0, 0, 17'(base), 0);
         for (int o = 0; o < 4; o += 2) runOp("loadH", LOADH, 1, 11, 0, 0, 17'(base + o), 0);
         for (int o = 0; o < 4; o++) runOp("loadB", LOADB, 1, 12, 0, 0, 17'(base + o), 0);
         // Byte and halfword stores step through every lane over the loop
         runOp("storeB", STOREB, 1, 5'(1 + nextRand() % 31), 0, 0,
               17'(base + i), 0);
         runOp("storeH", STOREH, 1, 5'(1 + nextRand() % 31), 0, 0,
               17'(base + 2 * (i % 2)), 0);
         runOp("loadMerged", LOADW, 1, 13, 0, 0, 17'(base), 0);
         runOp("loadWb", ADD, 0, 14, 12, 0, '0, 0);
      end

      // Misaligned accesses change nothing
      base = 4 * int'(nextRand() % 64);
      runOp("misSetup", ADD, 1, 15, 0, 0, 17'(nextRand()), 0);
      runOp("misLoadH", LOADH, 1, 15, 0, 0, 17'(base + 1), 0);
      runOp("misLoadW", LOADW, 1, 15, 0, 0, 17'(base + 2), 0);
      runOp("misStoreH", STOREH, 1, 7, 0, 0, 17'(base + 3), 0);
      runOp("misStoreW", STOREW, 1, 8, 0, 0, 17'(base + 1), 0);
      runOp("misRam", LOADW, 1, 16, 0, 0, 17'(base), 0);
      runOp("misReg", ADD, 0, 18, 15, 0, '0, 0);

      // Back-pressure, an accumulate shows any repeated execution
      for (int i = 0; i < 4; i++) begin
         runOp("backPressure", ADD, 1, 5, 5, 0, 17'(nextRand()), 1 + int'(nextRand() % 6));
         runOp("bpRead", ADD, 0, 17, 5, 0, '0, 0);
      end

      repeat (2) @(negedge gclk);
      if (u_wbTop.u_wbProps.failCount == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         $display("A handshake property of wbTop failed");
         reportFailure();
      end
   end

endmodule

//--- sim/wbProps.sv
/*
 * Handshake and reset properties for wbTop, attached by bind.
 * Sampled on the rising edge of gclk.
 * failCount counts failed properties for the testbench.
 */
module wbProps import coreDefs::*; (
   input logic             gclk,
   input logic             arstN,
   input logic             req,
   input logic             ack,
   input logic [dataW-1:0] rspData,
   input logic             misaligned
);

   int unsigned failCount = 0;

   // Quiet during and right after reset
   ackInReset: assert property (@(posedge gclk) !arstN |-> !ack)
      else begin
         $error("ack high during reset");
         failCount++;
      end

   ackAfterReset: assert property (@(posedge gclk) $rose(arstN) |-> !ack)
      else begin
         $error("ack high right after reset");
         failCount++;
      end

   // Rises only under a request, req seen on the edge that raised ack
   ackRise: assert property (@(posedge gclk) disable iff (!arstN) $rose(ack) |-> $past(req))
      else begin
         $error("ack rose without req");
         failCount++;
      end

   // Held req is back-pressure
   ackHold: assert property (@(posedge gclk) disable iff (!arstN) ack && req |=> ack)
      else begin
         $error("ack dropped while req held");
         failCount++;
      end

   ackFall: assert property (@(posedge gclk) disable iff (!arstN) ack && !req |=> !ack)
      else begin
         $error("ack not low one cycle after req low");
         failCount++;
      end

   rspStable: assert property (@(posedge gclk) disable iff (!arstN)
         ack |=> !ack || ($stable(rspData) && $stable(misaligned)))
      else begin
         $error("response changed while ack high");
         failCount++;
      end

endmodule

bind wbTop wbProps u_wbProps (
   .gclk       (gclk),
   .arstN      (arstN),
   .req        (req),
   .ack        (ack),
   .rspData    (rspData),
   .misaligned (misaligned)
);

//--- verilog/coreDefs.sv
/*
 * Shared widths, opcodes and bundles for the load/store write-back datapath.
 * Big-endian byte numbering. Byte offset 0 is bits [31:24] of a word.
 * The byte address is 8 bits wide, so only 64 RAM words are reachable.
 * Opcode values above STOREW are not defined. The sequencer acks them
 * without any register or RAM write.
 */
package coreDefs;

   // Datapath widths
   localparam int dataW     = 32;
   localparam int regAddrW  = 5;
   localparam int ramAddrW  = 6;
   localparam int byteAddrW = ramAddrW + 2;
   localparam int immW      = 17;
   localparam int regCount  = 1 << regAddrW;
   localparam int ramWords  = 1 << ramAddrW;

   // Operation kinds, low bits of the opcode field
   typedef enum logic [3:0] {
      ADD, SUB, AND, XOR,
      LOADB, LOADH, LOADW,
      STOREB, STOREH, STOREW
   } opKindE;

   // Register form, rd = ra op rb
   typedef struct packed {
      logic                immFlag;
      opKindE              opKind;
      logic [regAddrW-1:0] rd;
      logic [regAddrW-1:0] ra;
      logic [regAddrW-1:0] rb;
      logic [11:0]         unused;
   } regFormS;

   // Immediate form, also used by every load and store
   typedef struct packed {
      logic                immFlag;
      opKindE              opKind;
      logic [regAddrW-1:0] rd;
      logic [regAddrW-1:0] ra;
      logic [immW-1:0]     imm;
   } immFormS;

   // One operation word, two decodes picked by immFlag
   typedef union packed {
      regFormS regForm;
      immFormS immForm;
   } opWordU;

   typedef enum logic [1:0] {BYTE, HALF, WORD} accSizeE;

   // Write-back source, NONE leaves the destination alone
   typedef enum logic [1:0] {RESULT, LOADDATA, NONE} wbSrcE;

   // Sequencer to register file
   typedef struct packed {
      logic [regAddrW-1:0] raIdx;
      logic [regAddrW-1:0] rbIdx;
      logic [regAddrW-1:0] rdIdx;
      logic                writeEn;
      wbSrcE               wbSrc;
   } regCtlS;

   // Sequencer to aligner
   typedef struct packed {
      logic [byteAddrW-1:0] byteAddr;
      accSizeE              size;
      logic                 writeEn;
      logic [dataW-1:0]     storeData;
   } memReqS;

   // Aligner to RAM
   typedef struct packed {
      logic [ramAddrW-1:0] wordAddr;
      logic [3:0]          byteEn;
      logic                writeEn;
      logic [dataW-1:0]    writeData;
   } ramPortS;

endpackage

//--- verilog/dataRam.sv
/*
 * 64-word data RAM with one write enable per byte.
 * Read data is registered, one cycle of latency.
 * After reset a sweep writes zero to every word over 64 cycles.
 * ramBusy is high during the sweep and port writes are ignored then.
 */
module dataRam import coreDefs::*; (
   input  logic             gclk,
   input  logic             arstN,
   input  ramPortS          ramPort,
   output logic [dataW-1:0] ramData,
   output logic             ramBusy
);

   logic [dataW-1:0]    mem [ramWords];
   logic [ramAddrW-1:0] sweepAddr;

   // Clear sweep, one word per cycle
   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         ramBusy   <= 1'b1;
         sweepAddr <= '0;
      end else if (ramBusy) begin
         sweepAddr <= sweepAddr + 1'b1;
         // Last word cleared
         if (sweepAddr == '1) begin
            ramBusy <= 1'b0;
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (ramBusy) begin
         mem[sweepAddr] <= '0;
      end else if (ramPort.writeEn) begin
         for (int b = 0; b < 4; b++) begin
            if (ramPort.byteEn[b]) begin
               mem[ramPort.wordAddr][8*b +: 8] <= ramPort.writeData[8*b +: 8];
            end
         end
      end
      ramData <= mem[ramPort.wordAddr];
   end

endmodule

//--- verilog/memAlign.sv
/*
 * Load and store sizer between the sequencer and the data RAM.
 * Big-endian lanes. Offset 0 is the most significant byte and a
 * halfword at offset 0 is the upper half.
 * Alignment is not checked here. The sequencer drops writeEn on a
 * misaligned access, and the lane decode then only affects a load result
 * that is discarded.
 * Loads are zero-extended. Offset and size are held for the read cycle.
 */
module memAlign import coreDefs::*; (
   input  memReqS           memReq,
   output ramPortS          ramPort,
   input  logic [dataW-1:0] ramData,
   output logic [dataW-1:0] loadData,
   input  logic             gclk,
   input  logic             arstN
);

   logic [1:0] offset;
   logic [1:0] loadOff;
   accSizeE    loadSize;

   assign offset = memReq.byteAddr[1:0];

   // Store sizer
   always_comb begin
      ramPort.wordAddr  = memReq.byteAddr[byteAddrW-1:2];
      ramPort.writeEn   = memReq.writeEn;
      ramPort.byteEn    = 4'b0000;
      ramPort.writeData = '0;
      case (memReq.size)
         BYTE: begin
            // Byte lane walks down from the MSB as the offset grows
            ramPort.byteEn    = 4'b1000 >> offset;
            ramPort.writeData = {4{memReq.storeData[7:0]}};
         end
         HALF: begin
            ramPort.byteEn    = offset[1] ? 4'b0011 : 4'b1100;
            ramPort.writeData = {2{memReq.storeData[15:0]}};
         end
         WORD: begin
            ramPort.byteEn    = 4'b1111;
            ramPort.writeData = memReq.storeData;
         end
         default: begin
            ramPort.byteEn    = 4'b0000;
         end
      endcase
   end

   // RAM data comes back one cycle after the address
   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         loadOff  <= '0;
         loadSize <= WORD;
      end else begin
         loadOff  <= offset;
         loadSize <= memReq.size;
      end
   end

   // Load sizer
   always_comb begin
      case (loadSize)
         BYTE: begin
            case (loadOff)
               2'd0:    loadData = {24'd0, ramData[31:24]};
               2'd1:    loadData = {24'd0, ramData[23:16]};
               2'd2:    loadData = {24'd0, ramData[15:8]};
               default: loadData = {24'd0, ramData[7:0]};
            endcase
         end
         HALF:    loadData = loadOff[1] ? {16'd0, ramData[15:0]} : {16'd0, ramData[31:16]};
         WORD:    loadData = ramData;
         default: loadData = '0;
      endcase
   end

endmodule

//--- verilog/opSequencer.sv
/*
 * Four-phase req/ack slave and operation sequencer.
 * One operation in flight. opWord is captured on the accept edge.
 * ALU ops and stores ack one cycle after accept, loads two cycles after.
 * Misaligned halfword or word accesses skip all writes and ack with
 * rspData zero. A store returns its unsized source register on rspData.
 * No req is accepted while the RAM clear sweep runs.
 */
module opSequencer import coreDefs::*; (
   input  logic             gclk,
   input  logic             arstN,
   input  logic             req,
   input  opWordU           opWord,
   output logic             ack,
   output logic [dataW-1:0] rspData,
   output logic             misaligned,
   output regCtlS           regCtl,
   output logic [dataW-1:0] aluResult,
   input  logic [dataW-1:0] regA,
   input  logic [dataW-1:0] regB,
   input  logic [dataW-1:0] regD,
   output memReqS           memReq,
   input  logic [dataW-1:0] loadData,
   input  logic             ramBusy
);

   typedef enum logic [1:0] {IDLE, EXEC, LOADWAIT, ACKED} seqStateE;

   seqStateE         state;
   opWordU           opReg;
   opKindE           kind;
   accSizeE          accSize;
   logic             accept;
   logic             isImm;
   logic             isAlu;
   logic             isLoad;
   logic             isStore;
   logic             aligned;
   logic             misNext;
   logic [dataW-1:0] immExt;
   logic [dataW-1:0] opB;
   logic [dataW-1:0] effAddr;
   logic [dataW-1:0] respNext;

   // Idle implies ack is already low
   assign accept = (state == IDLE) && req && !ramBusy;

   // Opcode and flag sit at the same bits in both views
   assign kind    = opReg.regForm.opKind;
   assign isImm   = opReg.regForm.immFlag;
   assign isAlu   = kind inside {ADD, SUB, AND, XOR};
   assign isLoad  = kind inside {LOADB, LOADH, LOADW};
   assign isStore = kind inside {STOREB, STOREH, STOREW};
   assign immExt  = {{(dataW-immW){opReg.immForm.imm[immW-1]}}, opReg.immForm.imm};
   assign opB     = isImm ? immExt : regB;

   // ALU
   always_comb begin
      case (kind)
         ADD:     aluResult = regA + opB;
         SUB:     aluResult = regA - opB;
         AND:     aluResult = regA & opB;
         XOR:     aluResult = regA ^ opB;
         default: aluResult = '0;
      endcase
   end

   // Memory ops always take the immediate view
   assign effAddr = regA + immExt;

   always_comb begin
      case (kind)
         LOADB, STOREB: accSize = BYTE;
         LOADH, STOREH: accSize = HALF;
         default:       accSize = WORD;
      endcase
   end

   always_comb begin
      case (accSize)
         HALF:    aligned = !effAddr[0];
         WORD:    aligned = (effAddr[1:0] == 2'b00);
         default: aligned = 1'b1;
      endcase
   end

   assign misNext = (isLoad || isStore) && !aligned;

   // Register file control, rd doubles as the store data index
   always_comb begin
      regCtl.raIdx   = opReg.regForm.ra;
      regCtl.rbIdx   = opReg.regForm.rb;
      regCtl.rdIdx   = opReg.regForm.rd;
      regCtl.writeEn = 1'b0;
      regCtl.wbSrc   = NONE;
      if (state == EXEC && isAlu) begin
         regCtl.writeEn = 1'b1;
         regCtl.wbSrc   = RESULT;
      end else if (state == LOADWAIT && isLoad && aligned) begin
         regCtl.writeEn = 1'b1;
         regCtl.wbSrc   = LOADDATA;
      end
   end

   // Address is held into LOADWAIT, the write only fires in EXEC
   assign memReq.byteAddr  = effAddr[byteAddrW-1:0];
   assign memReq.size      = accSize;
   assign memReq.writeEn   = (state == EXEC) && isStore && aligned;
   assign memReq.storeData = regD;

   // Value returned with ack
   always_comb begin
      if (state == LOADWAIT) begin
         respNext = aligned ? loadData : '0;
      end else if (isAlu) begin
         respNext = aluResult;
      end else if (isStore && aligned) begin
         respNext = regD;
      end else begin
         respNext = '0;
      end
   end

   always_ff @(posedge gclk) begin
      if (accept) begin
         opReg <= opWord;
      end
   end

   // Handshake FSM
   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         state      <= IDLE;
         ack        <= 1'b0;
         misaligned <= 1'b0;
         rspData    <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (accept) begin
                  state <= EXEC;
               end
            end
            EXEC: begin
               if (isLoad) begin
                  state <= LOADWAIT;
               end else begin
                  ack        <= 1'b1;
                  misaligned <= misNext;
                  rspData    <= respNext;
                  state      <= ACKED;
               end
            end
            LOADWAIT: begin
               ack        <= 1'b1;
               misaligned <= misNext;
               rspData    <= respNext;
               state      <= ACKED;
            end
            ACKED: begin
               // Held req is back-pressure, wait for it to drop
               if (!req) begin
                  ack        <= 1'b0;
                  misaligned <= 1'b0;
                  state      <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

//--- verilog/regFile.sv
/*
 * 32 x 32 register file with read ports A, B and D.
 * Reads are combinational, the write lands at the clock edge.
 * Port D reads the rd index, which a store uses as its data source.
 * R0 is cleared by reset and never written, so it always reads zero.
 * No forwarding. The sequencer never reads a register in the write cycle.
 */
module regFile import coreDefs::*; (
   input  logic             gclk,
   input  logic             arstN,
   input  regCtlS           regCtl,
   input  logic [dataW-1:0] aluResult,
   input  logic [dataW-1:0] loadData,
   output logic [dataW-1:0] regA,
   output logic [dataW-1:0] regB,
   output logic [dataW-1:0] regD
);

   logic [dataW-1:0] regs [regCount];
   logic [dataW-1:0] wrData;
   logic             wrEn;

   // Three read ports over the same array
   assign regA = regs[regCtl.raIdx];
   assign regB = regs[regCtl.rbIdx];
   assign regD = regs[regCtl.rdIdx];

   // Destination mux
   always_comb begin
      case (regCtl.wbSrc)
         RESULT:   wrData = aluResult;
         LOADDATA: wrData = loadData;
         // Rewrite of the old value, never enabled below
         default:  wrData = regD;
      endcase
   end

   // Index 0 is a constant zero register
   assign wrEn = regCtl.writeEn && (regCtl.wbSrc != NONE) && (regCtl.rdIdx != '0);

   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[regCtl.rdIdx] <= wrData;
      end
   end

endmodule

//--- verilog/wbTop.sv
/*
 * Load/store and write-back datapath top level.
 * Four-phase req/ack. Hold opWord stable while req is high and raise
 * req again only after ack is seen low.
 * No req is taken for 64 cycles after reset while the RAM clears.
 */
module wbTop import coreDefs::*; (
   input  logic             gclk,
   input  logic             arstN,
   input  logic             req,
   input  opWordU           opWord,
   output logic             ack,
   output logic [dataW-1:0] rspData,
   output logic             misaligned
);

   regCtlS           regCtl;
   memReqS           memReq;
   ramPortS          ramPort;
   logic [dataW-1:0] aluResult;
   logic [dataW-1:0] regA;
   logic [dataW-1:0] regB;
   logic [dataW-1:0] regD;
   logic [dataW-1:0] ramData;
   logic [dataW-1:0] loadData;
   logic             ramBusy;

   // Handshake, decode and ALU
   opSequencer u_opSequencer (
      .gclk       (gclk),
      .arstN      (arstN),
      .req        (req),
      .opWord     (opWord),
      .ack        (ack),
      .rspData    (rspData),
      .misaligned (misaligned),
      .regCtl     (regCtl),
      .aluResult  (aluResult),
      .regA       (regA),
      .regB       (regB),
      .regD       (regD),
      .memReq     (memReq),
      .loadData   (loadData),
      .ramBusy    (ramBusy)
   );

   regFile u_regFile (
      .gclk      (gclk),
      .arstN     (arstN),
      .regCtl    (regCtl),
      .aluResult (aluResult),
      .loadData  (loadData),
      .regA      (regA),
      .regB      (regB),
      .regD      (regD)
   );

   // Sized loads feed both write-back and rspData
   memAlign u_memAlign (
      .memReq   (memReq),
      .ramPort  (ramPort),
      .ramData  (ramData),
      .loadData (loadData),
      .gclk     (gclk),
      .arstN    (arstN)
   );

   dataRam u_dataRam (
      .gclk    (gclk),
      .arstN   (arstN),
      .ramPort (ramPort),
      .ramData (ramData),
      .ramBusy (ramBusy)
   );

endmodule

//--- vlog.f
verilog/coreDefs.sv
verilog/regFile.sv
verilog/memAlign.sv
verilog/dataRam.sv
verilog/opSequencer.sv
verilog/wbTop.sv
sim/wbProps.sv
sim/tbWb.sv
